//--- hw/m_ext_macros.svh
// word width, iteration count and register map of the M-extension unit, include where needed
`ifndef M_EXT_MACROS_SVH
`define M_EXT_MACROS_SVH

// operand width in bits
`define M_XLEN 32

// one quotient or product bit per cycle
`define M_ITERS 32

// byte offsets on the Wishbone port
`define M_ADR_A      4'h0
`define M_ADR_B      4'h4
`define M_ADR_CTRL   4'h8
`define M_ADR_RESULT 4'hC

`endif

//--- hw/m_extension_pkg.sv
// operation codes and bus/request structs shared by the M-extension modules, import where used
`default_nettype none

`include "m_ext_macros.svh"

package m_extension_pkg;

    // funct3 encodings of the RISC-V M extension
    typedef enum logic [2:0] {
        mul    = 3'd0,
        mulh   = 3'd1,
        mulhsu = 3'd2,
        mulhu  = 3'd3,
        div    = 3'd4,
        divu   = 3'd5,
        rem    = 3'd6,
        remu   = 3'd7
    } m_funct3;

    // host to slave, Wishbone classic
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [3:0]          adr;
        logic [3:0]          sel;
        logic [`M_XLEN-1:0]  dat;
    } wb_req_t;

    // slave to host
    typedef struct packed {
        logic                ack;
        logic [`M_XLEN-1:0]  dat;
    } wb_rsp_t;

    // operation handed to the arithmetic unit
    typedef struct packed {
        m_funct3             op;
        logic [`M_XLEN-1:0]  a;
        logic [`M_XLEN-1:0]  b;
    } m_req_t;

endpackage

`default_nettype wire

//--- hw/m_multiplier.sv
// iterative shift-add multiplier for mul, mulh, mulhsu and mulhu, one bit of b per cycle
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_multiplier
    import m_extension_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire m_req_t            req,
    output logic                   done,
    output logic [`M_XLEN-1:0]     product
);

    localparam int CNT_W = $clog2(`M_ITERS + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_shift,
        s_done
    } state_t;

    state_t                 state;
    logic                   start_q;
    logic [CNT_W-1:0]       count;

    logic [2*`M_XLEN-1:0]   acc;
    logic [2*`M_XLEN-1:0]   mcand;
    logic [`M_XLEN-1:0]     mplier;
    logic                   b_signed;
    logic                   hi_word;

    logic                   a_signed;

    assign a_signed = (req.op == mulh) || (req.op == mulhsu);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= s_idle;
            start_q <= 1'b0;
            count   <= '0;
        end else begin
            start_q <= start;
            case (state)
                s_idle: begin
                    if (start_q) begin
                        state <= s_shift;
                        count <= CNT_W'(`M_ITERS);
                    end
                end
                s_shift: begin
                    count <= count - 1'b1;
                    if (count == CNT_W'(1)) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && start_q) begin
            acc      <= '0;
            mcand    <= {{`M_XLEN{a_signed & req.a[`M_XLEN-1]}}, req.a};
            mplier   <= req.b;
            b_signed <= (req.op == mulh);
            hi_word  <= (req.op != mul);
        end else if (state == s_shift) begin
            // sign bit of a signed b carries negative weight
            if (mplier[0]) begin
                if (b_signed && count == CNT_W'(1)) begin
                    acc <= acc - mcand;
                end else begin
                    acc <= acc + mcand;
                end
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign done    = (state == s_done);
    assign product = hi_word ? acc[2*`M_XLEN-1:`M_XLEN] : acc[`M_XLEN-1:0];

endmodule

`default_nettype wire

//--- hw/m_divider.sv
// radix-2 restoring divider for div, divu, rem and remu, started by a one-cycle start pulse
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_divider
    import m_extension_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire m_req_t            req,
    output logic                   done,
    output logic [`M_XLEN-1:0]     quotient,
    output logic [`M_XLEN-1:0]     remainder
);

    localparam int CNT_W = $clog2(`M_ITERS + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_shift,
        s_done
    } state_t;

    state_t                 state;
    logic                   start_q;
    logic [CNT_W-1:0]       count;

    // upper half partial remainder, lower half dividend shifting into quotient
    logic [2*`M_XLEN-1:0]   data;
    logic [`M_XLEN-1:0]     dvsr;
    logic                   q_neg;
    logic                   r_neg;

    logic                   signed_op;
    logic                   dvsr_zero;
    logic                   overflow;
    logic [`M_XLEN-1:0]     a_mag;
    logic [`M_XLEN-1:0]     b_mag;
    logic [`M_XLEN:0]       part;
    logic [`M_XLEN:0]       diff;

    assign signed_op = (req.op == div) || (req.op == rem);
    assign dvsr_zero = (req.b == '0);
    assign overflow  = signed_op && (req.a == {1'b1, {(`M_XLEN-1){1'b0}}}) && (&req.b);

    assign a_mag = (signed_op && req.a[`M_XLEN-1]) ? -req.a : req.a;
    assign b_mag = (signed_op && req.b[`M_XLEN-1]) ? -req.b : req.b;

    // shifted remainder needs one extra bit before the trial subtraction
    assign part = data[2*`M_XLEN-1:`M_XLEN-1];
    assign diff = part - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= s_idle;
            start_q <= 1'b0;
            count   <= '0;
        end else begin
            start_q <= start;
            case (state)
                s_idle: begin
                    if (start_q) begin
                        if (dvsr_zero || overflow) begin
                            state <= s_done;
                        end else begin
                            state <= s_shift;
                            count <= CNT_W'(`M_ITERS);
                        end
                    end
                end
                s_shift: begin
                    count <= count - 1'b1;
                    if (count == CNT_W'(1)) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && start_q) begin
            dvsr  <= b_mag;
            q_neg <= 1'b0;
            r_neg <= 1'b0;
            if (dvsr_zero) begin
                // all-ones quotient, dividend passes through as remainder
                data <= {req.a, {`M_XLEN{1'b1}}};
            end else if (overflow) begin
                data <= {{`M_XLEN{1'b0}}, 1'b1, {(`M_XLEN-1){1'b0}}};
            end else begin
                data  <= {{`M_XLEN{1'b0}}, a_mag};
                q_neg <= signed_op && (req.a[`M_XLEN-1] ^ req.b[`M_XLEN-1]);
                r_neg <= signed_op && req.a[`M_XLEN-1];
            end
        end else if (state == s_shift) begin
            if (!diff[`M_XLEN]) begin
                data <= {diff[`M_XLEN-1:0], data[`M_XLEN-2:0], 1'b1};
            end else begin
                data <= {part[`M_XLEN-1:0], data[`M_XLEN-2:0], 1'b0};
            end
        end
    end

    assign done = (state == s_done);

    // truncation toward zero, remainder follows the dividend
    assign quotient  = q_neg ? -data[`M_XLEN-1:0] : data[`M_XLEN-1:0];
    assign remainder = r_neg ? -data[2*`M_XLEN-1:`M_XLEN] : data[2*`M_XLEN-1:`M_XLEN];

endmodule

`default_nettype wire

//--- hw/m_unit.sv
// routes one M operation to the multiplier or the divider and returns busy, done and result
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_unit
    import m_extension_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire m_req_t            req,
    output logic                   busy,
    output logic                   done,
    output logic [`M_XLEN-1:0]     result
);

    logic                   busy_q;
    logic                   div_sel;
    logic                   mul_start;
    logic                   div_start;
    logic                   mul_done;
    logic                   div_done;
    logic [`M_XLEN-1:0]     product;
    logic [`M_XLEN-1:0]     quotient;
    logic [`M_XLEN-1:0]     remainder;

    // funct3 bit 2 splits divide ops from multiply ops
    assign div_sel   = req.op[2];
    assign mul_start = start && !busy_q && !div_sel;
    assign div_start = start && !busy_q && div_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (mul_start || div_start) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    assign busy = busy_q || mul_start || div_start;
    assign done = div_sel ? div_done : mul_done;

    // bit 1 picks rem/remu over div/divu
    always_comb begin
        if (!div_sel) begin
            result = product;
        end else if (req.op[1]) begin
            result = remainder;
        end else begin
            result = quotient;
        end
    end

    m_multiplier u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .req     (req),
        .done    (mul_done),
        .product (product)
    );

    m_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .req       (req),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

`default_nettype wire

//--- hw/m_wb_regs.sv
// Wishbone classic register block holding operands, control, status and the last result
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_wb_regs
    import m_extension_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire wb_req_t           wb_req,
    output wb_rsp_t                wb_rsp,
    input  wire logic              busy,
    input  wire logic              done,
    input  wire logic [`M_XLEN-1:0] result,
    output logic                   start,
    output m_req_t                 req
);

    logic                   ack_q;
    logic [`M_XLEN-1:0]     rdat_q;
    logic [`M_XLEN-1:0]     reg_a;
    logic [`M_XLEN-1:0]     reg_b;
    logic [`M_XLEN-1:0]     reg_result;
    m_funct3                op_q;
    logic                   done_q;
    logic                   start_q;

    logic                   access;
    logic                   wr;
    logic                   go;

    function automatic logic [`M_XLEN-1:0] merge_bytes(
        input logic [`M_XLEN-1:0] old_word,
        input logic [`M_XLEN-1:0] new_word,
        input logic [3:0]         sel
    );
        logic [`M_XLEN-1:0] word;
        word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                word[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return word;
    endfunction

    // a new request is taken only while no ack is outstanding
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr     = access && wb_req.we;
    assign go     = wr && (wb_req.adr == `M_ADR_CTRL) && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q      <= 1'b0;
            start_q    <= 1'b0;
            rdat_q     <= '0;
            reg_a      <= '0;
            reg_b      <= '0;
            reg_result <= '0;
            op_q       <= mul;
            done_q     <= 1'b0;
        end else begin
            ack_q   <= access;
            start_q <= go;

            if (wr && wb_req.adr == `M_ADR_A) begin
                reg_a <= merge_bytes(reg_a, wb_req.dat, wb_req.sel);
            end
            if (wr && wb_req.adr == `M_ADR_B) begin
                reg_b <= merge_bytes(reg_b, wb_req.dat, wb_req.sel);
            end
            if (go) begin
                op_q <= m_funct3'(wb_req.dat[2:0]);
            end

            // sticky until the next accepted start
            if (go) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end

            if (done) begin
                reg_result <= result;
            end

            if (access && !wb_req.we) begin
                case (wb_req.adr)
                    `M_ADR_A:      rdat_q <= reg_a;
                    `M_ADR_B:      rdat_q <= reg_b;
                    `M_ADR_CTRL:   rdat_q <= {{(`M_XLEN-2){1'b0}}, done_q, busy};
                    `M_ADR_RESULT: rdat_q <= reg_result;
                    default:       rdat_q <= '0;
                endcase
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    assign start  = start_q;
    assign req.op = op_q;
    assign req.a  = reg_a;
    assign req.b  = reg_b;

endmodule

`default_nettype wire

//--- hw/m_ext_top.sv
// top level of the M-extension unit, Wishbone slave in front of the arithmetic unit
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_ext_top
    import m_extension_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp
);

    logic                   start;
    logic                   busy;
    logic                   done;
    logic [`M_XLEN-1:0]     result;
    m_req_t                 req;

    m_wb_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .done   (done),
        .result (result),
        .start  (start),
        .req    (req)
    );

    m_unit u_unit (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

//--- verification/m_ext_tb.sv
// testbench for the M-extension unit, runs golden and random vectors over the Wishbone port
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_macros.svh"

module m_ext_tb
    import m_extension_pkg::*;
;

    localparam int ACK_LIMIT  = 20;
    localparam int DONE_LIMIT = 100;

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    int         tests;
    int         errors;
    int         bad;
    integer     seed;

    m_ext_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #4 clk = ~clk;

    // one classic cycle, request on a rising edge, ack sampled on falling edges
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [3:0] sel,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.sel <= sel;
        wb_req.dat <= wdat;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            $display("no ack from the DUT at address %h", adr);
            bad++;
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, sel, dat, unused);
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 4'hF, 32'd0, dat);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected)
        else begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            bad++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (bad != 0) begin
            errors++;
        end
        $display("%s : %s", name, (bad == 0) ? "ok" : "mismatch");
    endtask

    // load operands, start, poll status, read result; optionally retry CTRL while busy
    task automatic run_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] expected, input logic interfere, input string tag);
        logic [31:0] status;
        logic [31:0] res;
        int          polls;
        bad   = 0;
        polls = 0;
        bus_write(`M_ADR_A, a, 4'hF);
        bus_write(`M_ADR_B, b, 4'hF);
        bus_write(`M_ADR_CTRL, {29'd0, op}, 4'hF);
        bus_read(`M_ADR_CTRL, status);
        check_word("ctrl.busy", {31'd0, status[0]}, 32'd1);
        if (interfere) begin
            // flipping bit 2 would pick the other engine if it got through
            bus_write(`M_ADR_CTRL, {29'd0, op ^ 3'b100}, 4'hF);
        end
        while (!status[1] && polls < DONE_LIMIT) begin
            bus_read(`M_ADR_CTRL, status);
            polls++;
        end
        if (!status[1]) begin
            $display("status done never came for op %0d", op);
            bad++;
        end
        bus_read(`M_ADR_RESULT, res);
        check_word("result", res, expected);
        report_test($sformatf("%-9s op %0d a %h b %h", tag, op, a, b));
    endtask

    task automatic readback_test();
        logic [31:0] rd;
        bad = 0;
        bus_write(`M_ADR_A, 32'h12345678, 4'hF);
        bus_write(`M_ADR_A, 32'hAABBCCDD, 4'b0100);
        bus_read(`M_ADR_A, rd);
        check_word("reg_a", rd, 32'h12BB5678);
        bus_write(`M_ADR_B, 32'h0F0F0F0F, 4'hF);
        bus_write(`M_ADR_B, 32'h11223344, 4'b1001);
        bus_read(`M_ADR_B, rd);
        check_word("reg_b", rd, 32'h110F0F44);
        report_test("operand readback");
    endtask

    initial begin
        integer      fd;
        int          n;
        string       line;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        tests  = 0;
        errors = 0;
        bad    = 0;
        seed   = 83;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        readback_test();

        fd = $fopen("verification/m_ext_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden vector file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "/") continue;
                n = $sscanf(line, "%h %h %h %h", op, a, b, expected);
                if (n != 4) begin
                    $display("unreadable line in the golden file: %s", line);
                    errors++;
                end else begin
                    run_op(op[2:0], a, b, expected, 1'b0, "golden");
                end
            end
            $fclose(fd);
        end

        // 100 / 7 as div; a dropped start must leave the quotient alone
        run_op(3'd4, 32'd100, 32'd7, 32'd14, 1'b1, "busy ctrl");

        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_op(3'd0, a, b, a * b, 1'b0, "rand mul");
            run_op(3'd5, a, b, (b == 32'd0) ? 32'hFFFFFFFF : a / b, 1'b0, "rand divu");
        end

        $display("%0d tests run, %0d with errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/m_extension_pkg.sv
hw/m_multiplier.sv
hw/m_divider.sv
hw/m_unit.sv
hw/m_wb_regs.sv
hw/m_ext_top.sv
verification/m_ext_tb.sv

//--- Bender.yml
package:
  name: m_ext

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/m_extension_pkg.sv
      - hw/m_multiplier.sv
      - hw/m_divider.sv
      - hw/m_unit.sv
      - hw/m_wb_regs.sv
      - hw/m_ext_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/m_ext_tb.sv

//--- verification/m_ext_golden.txt
// op a b expected, all hex; op is the funct3 code, 0 mul through 7 remu
// multiply corners, then divide signs, zero divisor and signed overflow
0 00000001 ffffffff ffffffff
0 ffffffff ffffffff 00000001
0 80000000 80000000 00000000
0 80000000 ffffffff 80000000
0 00001234 00005678 06260060
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 80000000 ffffffff 00000000
1 00000001 ffffffff ffffffff
1 80000000 00000001 ffffffff
2 ffffffff ffffffff ffffffff
2 80000000 80000000 c0000000
2 00000001 ffffffff 00000000
2 80000000 ffffffff 80000000
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 80000000 ffffffff 7fffffff
3 00000000 ffffffff 00000000
4 fffffff9 00000002 fffffffd
6 fffffff9 00000002 ffffffff
4 00000007 fffffffe fffffffd
6 00000007 fffffffe 00000001
4 fffffff9 fffffffe 00000003
6 fffffff9 fffffffe ffffffff
5 fffffff9 00000002 7ffffffc
7 fffffff9 00000002 00000001
5 00000064 00000007 0000000e
7 00000064 00000007 00000002
4 80000000 00000002 c0000000
6 80000000 00000002 00000000
4 12345678 00000000 ffffffff
6 12345678 00000000 12345678
4 fffffff9 00000000 ffffffff
6 fffffff9 00000000 fffffff9
5 80000000 00000000 ffffffff
7 80000000 00000000 80000000
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000
5 80000000 ffffffff 00000000
7 80000000 ffffffff 80000000
